//--- hdl/stream_buffer_pkg.sv
`default_nettype none

package stream_buffer_pkg;

	// word and bank geometry.
	localparam int data_w = 16;
	localparam int addr_w = 10;

	// window scan pattern with line fastest and width slowest.
	localparam int line_count = 4;
	localparam int chan_count = 2;
	localparam int width_count = 8;
	localparam int width_stride = 4;
	localparam int scan_len = line_count * chan_count * width_count;

	localparam int line_w = $clog2(line_count);
	localparam int chan_w = $clog2(chan_count);
	localparam int width_w = $clog2(width_count);

	// address to data through the bank.
	localparam int read_latency = 3;
	localparam int drain_w = $clog2(read_latency);

	typedef enum logic [1:0] {
		scan_idle,
		scan_run,
		scan_drain,
		scan_ack
	} scan_state_t;

endpackage

`default_nettype wire

//--- hdl/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram (
	input  wire                                   clk,
	input  wire  [stream_buffer_pkg::addr_w-1:0] i_addr1,
	input  wire  [stream_buffer_pkg::addr_w-1:0] i_addr2,
	input  wire  [stream_buffer_pkg::data_w-1:0] i_data1,
	input  wire  [stream_buffer_pkg::data_w-1:0] i_data2,
	input  wire                                   i_we1,
	input  wire                                   i_we2,
	output logic [stream_buffer_pkg::data_w-1:0] o_out1,
	output logic [stream_buffer_pkg::data_w-1:0] o_out2
);

	import stream_buffer_pkg::*;

	localparam int depth = 1 << addr_w;

	logic [data_w-1:0] mem [0:depth-1];

	// write has priority on each port, otherwise a registered read.
	always_ff @(posedge clk) begin
		if (i_we1) begin
			mem[i_addr1] <= i_data1;
		end else begin
			o_out1 <= mem[i_addr1];
		end

		if (i_we2) begin
			mem[i_addr2] <= i_data2;
		end else begin
			o_out2 <= mem[i_addr2];
		end
	end

endmodule

`default_nettype wire

//--- hdl/feature_bank.sv
`timescale 1ns/1ps
`default_nettype none

module feature_bank (
	input  wire                                   clk,
	input  wire                                   i_wen,
	input  wire  [stream_buffer_pkg::addr_w-1:0] i_waddr,
	input  wire  [stream_buffer_pkg::data_w-1:0] i_wdata,
	input  wire  [stream_buffer_pkg::addr_w-1:0] i_raddr,
	output logic [stream_buffer_pkg::data_w-1:0] o_rdata
);

	import stream_buffer_pkg::*;

	logic [addr_w-1:0] raddr_q;
	logic [data_w-1:0] ram_rdata;
	logic [data_w-1:0] rdata_q;

	// address register in front of the ram.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
	end

	// port 1 only writes, port 2 only reads.
	dual_port_ram ram_inst (
		.clk     (clk),
		.i_addr1 (i_waddr),
		.i_addr2 (raddr_q),
		.i_data1 (i_wdata),
		.i_data2 ('0),
		.i_we1   (i_wen),
		.i_we2   (1'b0),
		.o_out1  (),
		.o_out2  (ram_rdata)
	);

	// output register as the third read stage.
	always_ff @(posedge clk) begin
		rdata_q <= ram_rdata;
	end

	assign o_rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/scan_address_gen.sv
`timescale 1ns/1ps
`default_nettype none

module scan_address_gen (
	input  wire                                   clk,
	input  wire                                   i_reset,
	input  wire                                   i_enable,
	output logic [stream_buffer_pkg::addr_w-1:0] o_addr,
	output logic                                  o_last
);

	import stream_buffer_pkg::*;

	logic [line_w-1:0]  line_cnt;
	logic [chan_w-1:0]  chan_cnt;
	logic [width_w-1:0] width_cnt;

	logic line_end;
	logic chan_end;
	logic width_end;

	logic [addr_w-1:0] width_base;

	assign line_end = (line_cnt == line_w'(line_count - 1));
	assign chan_end = (chan_cnt == chan_w'(chan_count - 1));
	assign width_end = (width_cnt == width_w'(width_count - 1));

	// line wraps into channel, channel wraps into width.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			line_cnt <= '0;
			chan_cnt <= '0;
			width_cnt <= '0;
		end else if (i_enable) begin
			if (line_end) begin
				line_cnt <= '0;
				if (chan_end) begin
					chan_cnt <= '0;
					if (width_end) begin
						width_cnt <= '0;
					end else begin
						width_cnt <= width_cnt + 1'b1;
					end
				end else begin
					chan_cnt <= chan_cnt + 1'b1;
				end
			end else begin
				line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	// windows step by width_stride, so neighbours overlap.
	assign width_base = addr_w'(width_cnt) * addr_w'(width_stride);

	always_comb begin
		o_addr = width_base + addr_w'(chan_cnt) + addr_w'(line_cnt);
	end

	// final address of the pass.
	assign o_last = line_end && chan_end && width_end;

endmodule

`default_nettype wire

//--- hdl/stream_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_buffer (
	input  wire                                   clk,
	input  wire                                   i_reset,
	input  wire                                   i_wen0,
	input  wire  [stream_buffer_pkg::data_w-1:0] i_ddr,
	input  wire                                   i_wen1,
	input  wire  [stream_buffer_pkg::addr_w-1:0] i_waddr,
	input  wire  [stream_buffer_pkg::data_w-1:0] i_pool,
	input  wire  [stream_buffer_pkg::data_w-1:0] i_eltwise,
	input  wire                                   i_eltwise_sel,
	input  wire                                   i_scan_req,
	output logic                                  o_scan_ack,
	output logic                                  o_feature_valid,
	output logic [stream_buffer_pkg::data_w-1:0] o_feature_0,
	output logic [stream_buffer_pkg::data_w-1:0] o_feature_1
);

	import stream_buffer_pkg::*;

	scan_state_t state;

	logic [drain_w-1:0]      drain_cnt;
	logic [read_latency-1:0] valid_sr;

	logic              scan_running;
	logic [addr_w-1:0] scan_addr;
	logic              scan_last;

	logic              bank0_wen;
	logic [data_w-1:0] bank1_wdata;

	assign scan_running = (state == scan_run);

	// four-phase handshake around one scan pass.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= scan_idle;
			drain_cnt <= '0;
		end else begin
			case (state)
				scan_idle: begin
					if (i_scan_req) begin
						state <= scan_run;
					end
				end
				scan_run: begin
					drain_cnt <= '0;
					if (scan_last) begin
						state <= scan_drain;
					end
				end
				scan_drain: begin
					// wait out the bank read pipeline.
					if (drain_cnt == drain_w'(read_latency - 1)) begin
						state <= scan_ack;
					end else begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				scan_ack: begin
					if (!i_scan_req) begin
						state <= scan_idle;
					end
				end
				default: begin
					state <= scan_idle;
				end
			endcase
		end
	end

	assign o_scan_ack = (state == scan_ack);

	// valid follows each address through the read stages.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[read_latency-2:0], scan_running};
		end
	end

	assign o_feature_valid = valid_sr[read_latency-1];

	scan_address_gen scan_gen_inst (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_enable (scan_running),
		.o_addr   (scan_addr),
		.o_last   (scan_last)
	);

	// ddr fill only lands while the scan walks the addresses.
	assign bank0_wen = i_wen0 && scan_running;

	feature_bank bank0_inst (
		.clk     (clk),
		.i_wen   (bank0_wen),
		.i_waddr (scan_addr),
		.i_wdata (i_ddr),
		.i_raddr (scan_addr),
		.o_rdata (o_feature_0)
	);

	// partial results come from eltwise or pooling.
	assign bank1_wdata = i_eltwise_sel ? i_eltwise : i_pool;

	feature_bank bank1_inst (
		.clk     (clk),
		.i_wen   (i_wen1),
		.i_waddr (i_waddr),
		.i_wdata (bank1_wdata),
		.i_raddr (scan_addr),
		.o_rdata (o_feature_1)
	);

endmodule

`default_nettype wire

//--- bench/stream_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stream_buffer_tb;

	import stream_buffer_pkg::*;

	logic              clk;
	logic              i_reset;
	logic              i_wen0;
	logic [data_w-1:0] i_ddr;
	logic              i_wen1;
	logic [addr_w-1:0] i_waddr;
	logic [data_w-1:0] i_pool;
	logic [data_w-1:0] i_eltwise;
	logic              i_eltwise_sel;
	logic              i_scan_req;
	logic              o_scan_ack;
	logic              o_feature_valid;
	logic [data_w-1:0] o_feature_0;
	logic [data_w-1:0] o_feature_1;

	// reference contents of both banks.
	logic [data_w-1:0] model0 [0:(1<<addr_w)-1];
	logic [data_w-1:0] model1 [0:(1<<addr_w)-1];

	int cycle = 0;
	int accept_cycle = -1000;
	int valid_seen = 0;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	bit check0 = 1'b0;
	bit check1 = 1'b0;
	bit checks_on = 1'b0;

	stream_buffer stream_buffer_inst (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_wen0          (i_wen0),
		.i_ddr           (i_ddr),
		.i_wen1          (i_wen1),
		.i_waddr         (i_waddr),
		.i_pool          (i_pool),
		.i_eltwise       (i_eltwise),
		.i_eltwise_sel   (i_eltwise_sel),
		.i_scan_req      (i_scan_req),
		.o_scan_ack      (o_scan_ack),
		.o_feature_valid (o_feature_valid),
		.o_feature_0     (o_feature_0),
		.o_feature_1     (o_feature_1)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic note_mismatch(input string msg);
		errors++;
		$display("[FAIL] t=%0t %s", $time, msg);
	endtask

	// window order is line fastest, then channel, then width.
	function automatic logic [addr_w-1:0] scan_addr_of(input int idx);
		int line_i;
		int chan_i;
		int width_i;
		line_i = idx % line_count;
		chan_i = (idx / line_count) % chan_count;
		width_i = idx / (line_count * chan_count);
		return addr_w'(width_i * width_stride + chan_i + line_i);
	endfunction

	assert property (@(posedge clk) disable iff (i_reset) !(o_scan_ack && o_feature_valid))
		else note_mismatch("o_scan_ack and o_feature_valid high together");
	assert property (@(posedge clk) disable iff (i_reset)
		$rose(o_scan_ack) |-> $past(o_feature_valid))
		else note_mismatch("o_scan_ack rose without a valid word on the cycle before");
	assert property (@(posedge clk) disable iff (i_reset)
		(o_scan_ack && i_scan_req) |=> o_scan_ack)
		else note_mismatch("o_scan_ack fell while i_scan_req was still held");
	assert property (@(posedge clk) disable iff (i_reset)
		(o_scan_ack && !i_scan_req) |=> !o_scan_ack)
		else note_mismatch("o_scan_ack stayed high after i_scan_req dropped");

	// per-cycle compare of valid and both feature words.
	always @(negedge clk) begin
		int offs;
		logic exp_valid;
		logic [addr_w-1:0] addr;
		if (checks_on) begin
			offs = cycle - accept_cycle;
			exp_valid = (offs >= read_latency) && (offs < read_latency + scan_len);
			checks++;
			assert (o_feature_valid === exp_valid)
				else note_mismatch($sformatf("o_feature_valid %b, expected %b (offset %0d)",
					o_feature_valid, exp_valid, offs));
			if (o_feature_valid && exp_valid) begin
				valid_seen++;
				addr = scan_addr_of(offs - read_latency);
				if (check0) begin
					checks++;
					assert (o_feature_0 === model0[addr])
						else note_mismatch($sformatf("o_feature_0 addr %0d: got %h expected %h",
							addr, o_feature_0, model0[addr]));
				end
				if (check1) begin
					checks++;
					assert (o_feature_1 === model1[addr])
						else note_mismatch($sformatf("o_feature_1 addr %0d: got %h expected %h",
							addr, o_feature_1, model1[addr]));
				end
			end
		end
	end

	task automatic await_ack(input logic level, input int limit);
		int n;
		n = 0;
		while (o_scan_ack !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (o_scan_ack !== level) begin
			$display("timeout: o_scan_ack did not reach %0b within %0d cycles", level, limit);
			timeouts++;
			errors++;
		end
	endtask

	task automatic write_bank1(input logic [addr_w-1:0] addr, input logic sel,
		input logic [data_w-1:0] pool, input logic [data_w-1:0] elt);
		@(negedge clk);
		i_wen1 = 1'b1;
		i_waddr = addr;
		i_eltwise_sel = sel;
		i_pool = pool;
		i_eltwise = elt;
		model1[addr] = sel ? elt : pool;
	endtask

	task automatic scatter_bank1(input int count);
		for (int k = 0; k < count; k++) begin
			write_bank1(addr_w'($urandom_range(0, 63)), 1'($urandom),
				data_w'($urandom), data_w'($urandom));
		end
		@(negedge clk);
		i_wen1 = 1'b0;
	endtask

	// one full handshake that may also fill bank 0 along the scan.
	task automatic run_pass(input bit fill0, input bit chk0, input bit chk1);
		int hold;
		logic [data_w-1:0] word;
		await_ack(1'b0, 20);
		check0 = chk0;
		check1 = chk1;
		valid_seen = 0;
		i_scan_req = 1'b1;
		accept_cycle = cycle + 1;
		if (fill0) begin
			for (int k = 0; k < scan_len; k++) begin
				@(negedge clk);
				word = data_w'($urandom);
				i_wen0 = 1'b1;
				i_ddr = word;
				model0[scan_addr_of(k)] = word;
			end
			@(negedge clk);
			i_wen0 = 1'b0;
		end
		await_ack(1'b1, scan_len + read_latency + 20);
		checks++;
		assert (cycle == accept_cycle + scan_len + read_latency)
			else note_mismatch($sformatf("o_scan_ack rose %0d cycles after accept",
				cycle - accept_cycle));
		hold = $urandom_range(0, 6);
		repeat (hold) @(negedge clk);
		i_scan_req = 1'b0;
		@(negedge clk);
		checks += 2;
		assert (!o_scan_ack)
			else note_mismatch("o_scan_ack still high one cycle after i_scan_req fell");
		assert (valid_seen == scan_len)
			else note_mismatch($sformatf("%0d valid cycles in pass", valid_seen));
		check0 = 1'b0;
		check1 = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hf2df));
		i_reset = 1'b1;
		i_wen0 = 1'b0;
		i_ddr = '0;
		i_wen1 = 1'b0;
		i_waddr = '0;
		i_pool = '0;
		i_eltwise = '0;
		i_eltwise_sel = 1'b0;
		i_scan_req = 1'b0;
		repeat (8) @(negedge clk);
		i_reset = 1'b0;
		checks_on = 1'b1;

		// idle after reset with no request.
		repeat (10) begin
			@(negedge clk);
			checks++;
			assert (!o_scan_ack && !o_feature_valid)
				else note_mismatch("ack or valid high while idle after reset");
		end

		// known pattern over every address a scan can reach.
		for (int a = 0; a < 64; a++) begin
			write_bank1(addr_w'(a), 1'b0, data_w'(a * 40503) ^ 16'h3c5a, '0);
		end
		scatter_bank1(48);

		run_pass(1'b1, 1'b0, 1'b1);
		run_pass(1'b0, 1'b1, 1'b1);
		run_pass(1'b0, 1'b1, 1'b1);

		scatter_bank1(32);
		run_pass(1'b1, 1'b0, 1'b1);
		run_pass(1'b0, 1'b1, 1'b1);
		repeat (4) @(negedge clk);

		$display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- stream_buffer.f
hdl/stream_buffer_pkg.sv
hdl/dual_port_ram.sv
hdl/feature_bank.sv
hdl/scan_address_gen.sv
hdl/stream_buffer.sv
bench/stream_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module stream_buffer_tb \
	-Mdir "$build_dir" \
	-f stream_buffer.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/Vstream_buffer_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q '^>>> PASS$' "$log_file"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $log_file"
	exit 1
fi
